/* logic/ntt_pkg.sv */
package ntt_pkg;

  ////////////////////
  // Sizes

  localparam int N_COEF     = 16;
  localparam int ADDR_W     = 4;
  localparam int DATA_W     = 14;
  localparam int Q          = 12289;
  localparam int N_BANKS    = 4;
  localparam int ROW_W      = 2;
  localparam int BANK_W     = 2;
  localparam int N_BF       = 2;
  localparam int N_LANES    = 4;
  localparam int STAGES     = 4;
  localparam int GROUPS     = 4;
  localparam int PIPE_DEPTH = 3;
  localparam int NTT_CYCLES = STAGES * (GROUPS + PIPE_DEPTH);
  localparam int TW_N       = 8;
  localparam int TW_W       = 3;

  // Plain repeated multiply, only evaluated at elaboration
  function automatic int pow_mod(int base, int e);
    int acc;
    acc = 1;
    for (int i = 0; i < e; i++) begin
      acc = (acc * base) % Q;
    end
    return acc;
  endfunction

  // 7 is a primitive 2048th root, so this is a primitive 16th root
  localparam int OMEGA = pow_mod(7, 128);

  ////////////////////
  // Types

  typedef logic [DATA_W-1:0] coef_t;
  typedef logic [ADDR_W-1:0] caddr_t;
  typedef logic [BANK_W-1:0] bank_t;
  typedef logic [ROW_W-1:0]  row_t;
  typedef logic [TW_W-1:0]   texp_t;

  typedef enum logic [1:0] {ST_IDLE, ST_ISSUE, ST_DRAIN} ctrl_state_e;

  typedef struct packed {
    logic   en;
    caddr_t addr;
    coef_t  data;
  } host_wr_t;

  // One exponent per butterfly
  typedef struct packed {
    logic                  valid;
    caddr_t [N_LANES-1:0]  addr;
    texp_t  [N_BF-1:0]     texp;
  } issue_t;

  typedef struct packed {
    logic                 valid;
    row_t  [N_BANKS-1:0]  row;
    bank_t [N_LANES-1:0]  lane;
  } route_t;

  ////////////////////
  // Mapping

  // Digit sum modulo 4
  function automatic bank_t bank_of(caddr_t a);
    return bank_t'(a[ADDR_W-1:ROW_W] + a[ROW_W-1:0]);
  endfunction

  function automatic row_t row_of(caddr_t a);
    return a[ADDR_W-1:ROW_W];
  endfunction

  function automatic coef_t tw_value(int e);
    return coef_t'(pow_mod(OMEGA, e));
  endfunction

endpackage

/* logic/ntt_ctrl.sv */
`timescale 1ns/1ns

module ntt_ctrl (
  input  logic            clk,
  input  logic            rst,
  input  logic            start,
  output logic            busy,
  output logic            done,
  output ntt_pkg::issue_t issue
);
  import ntt_pkg::*;

  ctrl_state_e state;
  logic [1:0]  stage;
  logic [1:0]  group;
  logic [1:0]  drain;
  caddr_t      h;
  caddr_t      partner;
  caddr_t      base;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
      stage <= '0;
      group <= '0;
      drain <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_ISSUE;
            stage <= '0;
            group <= '0;
          end
        end
        ST_ISSUE: begin
          group <= group + 1'b1;
          if (group == GROUPS - 1) begin
            state <= ST_DRAIN;
            drain <= '0;
          end
        end
        ST_DRAIN: begin
          drain <= drain + 1'b1;
          // Last write of the stage lands before the next read
          if (drain == PIPE_DEPTH - 1) begin
            stage <= stage + 1'b1;
            if (stage == STAGES - 1) begin
              state <= ST_IDLE;
              done  <= 1'b1;
            end else begin
              state <= ST_ISSUE;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign busy = (state != ST_IDLE);

  ////////////////////
  // Address generator

  always_comb begin
    h       = caddr_t'(N_COEF / 2) >> stage;
    partner = stage[0] ? (h << 1) : (h >> 1);
    // Group counter fills the digit that holds neither h nor partner
    base    = stage[1] ? {group, 2'b00} : {2'b00, group};

    issue.valid   = (state == ST_ISSUE);
    issue.addr[0] = base;
    issue.addr[1] = base | h;
    issue.addr[2] = base | partner;
    issue.addr[3] = base | h | partner;
    // Offset within the block, scaled to the 16th root
    issue.texp[0] = texp_t'((issue.addr[0] & (h - 1'b1)) << stage);
    issue.texp[1] = texp_t'((issue.addr[2] & (h - 1'b1)) << stage);
  end

endmodule

/* logic/bank_map.sv */
`timescale 1ns/1ns

module bank_map (
  input  logic            clk,
  input  logic            rst,
  input  ntt_pkg::issue_t issue,
  output ntt_pkg::route_t rd_route,
  output ntt_pkg::route_t wr_route
);
  import ntt_pkg::*;

  route_t [PIPE_DEPTH-1:0] line_q;
  bank_t  [N_LANES-1:0]    lane_bank;

  ////////////////////
  // Memory map

  always_comb begin
    for (int l = 0; l < N_LANES; l++) begin
      lane_bank[l] = bank_of(issue.addr[l]);
    end
  end

  ////////////////////
  // Bank input network

  // Lanes of one group never share a bank
  always_comb begin
    rd_route       = '0;
    rd_route.valid = issue.valid;
    for (int l = 0; l < N_LANES; l++) begin
      rd_route.lane[l]               = lane_bank[l];
      rd_route.row[lane_bank[l]]     = row_of(issue.addr[l]);
    end
  end

  ////////////////////
  // Write-back delay

  always_ff @(posedge clk) begin
    if (rst) begin
      line_q <= '0;
    end else begin
      line_q[0] <= rd_route;
      for (int i = 1; i < PIPE_DEPTH; i++) begin
        line_q[i] <= line_q[i-1];
      end
    end
  end

  // Matches bank read, ROM read and two butterfly stages
  assign wr_route = line_q[PIPE_DEPTH-1];

endmodule

/* logic/coeff_banks.sv */
`timescale 1ns/1ns

module coeff_banks (
  input  logic                                  clk,
  input  logic                                  busy,
  input  ntt_pkg::host_wr_t                     host_wr,
  input  logic                                  rd_en,
  input  ntt_pkg::caddr_t                       rd_addr,
  input  ntt_pkg::route_t                       rd_route,
  input  ntt_pkg::route_t                       wr_route,
  input  ntt_pkg::coef_t [ntt_pkg::N_BANKS-1:0] wr_data,
  output ntt_pkg::coef_t [ntt_pkg::N_BANKS-1:0] q,
  output ntt_pkg::coef_t                        rd_data
);
  import ntt_pkg::*;

  coef_t mem [N_BANKS][2**ROW_W];

  logic  [N_BANKS-1:0] we;
  logic  [N_BANKS-1:0] re;
  row_t  [N_BANKS-1:0] wa;
  row_t  [N_BANKS-1:0] ra;
  coef_t [N_BANKS-1:0] wd;
  bank_t               rd_bank_q;

  // Host owns the ports only while idle
  always_comb begin
    for (int b = 0; b < N_BANKS; b++) begin
      if (busy) begin
        we[b] = wr_route.valid;
        wa[b] = wr_route.row[b];
        wd[b] = wr_data[b];
        re[b] = rd_route.valid;
        ra[b] = rd_route.row[b];
      end else begin
        we[b] = host_wr.en && (bank_of(host_wr.addr) == bank_t'(b));
        wa[b] = row_of(host_wr.addr);
        wd[b] = host_wr.data;
        re[b] = rd_en && (bank_of(rd_addr) == bank_t'(b));
        ra[b] = row_of(rd_addr);
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int b = 0; b < N_BANKS; b++) begin
      if (we[b])
        mem[b][wa[b]] <= wd[b];
      if (re[b])
        q[b] <= mem[b][ra[b]];
    end
    if (rd_en && !busy)
      rd_bank_q <= bank_of(rd_addr);
  end

  assign rd_data = q[rd_bank_q];

endmodule

/* logic/twiddle_rom.sv */
`timescale 1ns/1ns

module twiddle_rom (
  input  logic                                  clk,
  input  ntt_pkg::texp_t [ntt_pkg::N_BF-1:0]    texp,
  output ntt_pkg::coef_t [ntt_pkg::N_BF-1:0]    w
);
  import ntt_pkg::*;

  coef_t rom [TW_N];

  // Powers of omega, constant after elaboration
  for (genvar e = 0; e < TW_N; e++) begin : g_fill
    assign rom[e] = tw_value(e);
  end

  // One read port per butterfly, same latency as the banks
  always_ff @(posedge clk) begin
    for (int i = 0; i < N_BF; i++) begin
      w[i] <= rom[texp[i]];
    end
  end

endmodule

/* logic/mod_butterfly.sv */
`timescale 1ns/1ns

module mod_butterfly (
  input  logic           clk,
  input  ntt_pkg::coef_t u,
  input  ntt_pkg::coef_t v,
  input  ntt_pkg::coef_t w,
  output ntt_pkg::coef_t upper,
  output ntt_pkg::coef_t lower
);
  import ntt_pkg::*;

  logic [DATA_W:0]     sum_raw;
  coef_t               sum_mod;
  coef_t               diff;
  coef_t               sum_q;
  logic [2*DATA_W-1:0] prod_q;

  always_comb begin
    sum_raw = {1'b0, u} + {1'b0, v};
    sum_mod = (sum_raw >= Q) ? coef_t'(sum_raw - Q) : coef_t'(sum_raw);
    // Wrap the difference back into [0, Q)
    diff    = (u >= v) ? coef_t'(u - v) : coef_t'(Q - v + u);
  end

  // Stage 1 sum and raw product
  always_ff @(posedge clk) begin
    sum_q  <= sum_mod;
    prod_q <= diff * w;
  end

  // Stage 2 reduction
  always_ff @(posedge clk) begin
    upper <= sum_q;
    lower <= coef_t'(prod_q % Q);
  end

endmodule

/* logic/bf_array.sv */
`timescale 1ns/1ns

module bf_array (
  input  logic                                  clk,
  input  ntt_pkg::route_t                       rd_route,
  input  ntt_pkg::route_t                       wr_route,
  input  ntt_pkg::coef_t [ntt_pkg::N_BANKS-1:0] q,
  input  ntt_pkg::coef_t [ntt_pkg::N_BF-1:0]    w,
  output ntt_pkg::coef_t [ntt_pkg::N_BANKS-1:0] wr_data
);
  import ntt_pkg::*;

  bank_t [N_LANES-1:0] lane_q;
  coef_t [N_LANES-1:0] x;
  wire coef_t          y [N_LANES];

  ////////////////////
  // Input network

  // Lane banks follow the data through the bank read
  always_ff @(posedge clk) begin
    lane_q <= rd_route.lane;
  end

  always_comb begin
    for (int l = 0; l < N_LANES; l++) begin
      x[l] = q[lane_q[l]];
    end
  end

  for (genvar i = 0; i < N_BF; i++) begin : g_bf
    mod_butterfly i_bf (
      .clk   (clk),
      .u     (x[2*i]),
      .v     (x[2*i+1]),
      .w     (w[i]),
      .upper (y[2*i]),
      .lower (y[2*i+1])
    );
  end

  ////////////////////
  // Output network

  always_comb begin
    wr_data = '0;
    for (int l = 0; l < N_LANES; l++) begin
      wr_data[wr_route.lane[l]] = y[l];
    end
  end

endmodule

/* logic/ntt_top.sv */
`timescale 1ns/1ns

module ntt_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  output logic              busy,
  output logic              done,
  input  ntt_pkg::host_wr_t host_wr,
  input  logic              rd_en,
  input  ntt_pkg::caddr_t   rd_addr,
  output ntt_pkg::coef_t    rd_data
);
  import ntt_pkg::*;

  issue_t                issue;
  route_t                rd_route;
  route_t                wr_route;
  coef_t [N_BANKS-1:0]   bank_q;
  coef_t [N_BANKS-1:0]   wr_data;
  coef_t [N_BF-1:0]      w;

  ntt_ctrl i_ctrl (
    .clk   (clk),
    .rst   (rst),
    .start (start),
    .busy  (busy),
    .done  (done),
    .issue (issue)
  );

  bank_map i_map (
    .clk      (clk),
    .rst      (rst),
    .issue    (issue),
    .rd_route (rd_route),
    .wr_route (wr_route)
  );

  coeff_banks i_banks (
    .clk      (clk),
    .busy     (busy),
    .host_wr  (host_wr),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_route (rd_route),
    .wr_route (wr_route),
    .wr_data  (wr_data),
    .q        (bank_q),
    .rd_data  (rd_data)
  );

  twiddle_rom i_rom (
    .clk  (clk),
    .texp (issue.texp),
    .w    (w)
  );

  bf_array i_bf (
    .clk      (clk),
    .rd_route (rd_route),
    .wr_route (wr_route),
    .q        (bank_q),
    .w        (w),
    .wr_data  (wr_data)
  );

endmodule

/* tests/ntt_chk.sv */
`timescale 1ns/1ns

module ntt_chk (
  input logic            clk,
  input logic            rst,
  input logic            start,
  input logic            busy,
  input logic            done,
  input ntt_pkg::route_t rd_route
);
  import ntt_pkg::*;

  int fail_cnt = 0;

  function automatic logic lanes_apart(route_t r);
    for (int i = 0; i < N_LANES; i++) begin
      for (int j = i + 1; j < N_LANES; j++) begin
        if (r.lane[i] == r.lane[j])
          return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  a_bank_conflict: assert property (@(posedge clk) disable iff (rst)
    rd_route.valid |-> lanes_apart(rd_route))
    else begin
      $error("two lanes of one group share a bank");
      fail_cnt++;
    end

  a_done_pulse: assert property (@(posedge clk) disable iff (rst)
    done |=> !done)
    else begin
      $error("done held for more than one cycle");
      fail_cnt++;
    end

  a_done_idle: assert property (@(posedge clk) disable iff (rst)
    !(done && busy))
    else begin
      $error("done and busy high together");
      fail_cnt++;
    end

  // Busy for the whole transform, then done
  a_busy_run: assert property (@(posedge clk) disable iff (rst)
    (start && !busy) |=> busy [*NTT_CYCLES] ##1 done)
    else begin
      $error("busy dropped or done missing after start");
      fail_cnt++;
    end

endmodule

bind ntt_top ntt_chk i_chk (
  .clk      (clk),
  .rst      (rst),
  .start    (start),
  .busy     (busy),
  .done     (done),
  .rd_route (rd_route)
);

/* tests/ntt_tb.sv */
`timescale 1ns/1ns

module ntt_tb;
  import ntt_pkg::*;

  // 13 vectors of about 65 cycles each, reset and idle checks, doubled
  localparam int          TIMEOUT_CYCLES = 2000;
  localparam logic [31:0] SEED           = 32'hd6ce;
  localparam logic [31:0] TAPS           = 32'hd000_0001;

  logic     clk = 1'b0;
  logic     rst;
  logic     start;
  logic     busy;
  logic     done;
  host_wr_t host_wr;
  logic     rd_en;
  caddr_t   rd_addr;
  coef_t    rd_data;

  logic [31:0] lfsr;
  int          cycle_cnt = 0;
  int          done_cnt = 0;
  int          done_mark;
  int          err_count = 0;
  int          test_count = 0;
  int          fail_count = 0;
  int          test_err_start;
  int          omega_pow [N_COEF];
  coef_t       vec [N_COEF];
  coef_t       expect_mem [N_COEF];
  coef_t       got [N_COEF];

  ntt_top i_dut (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .busy    (busy),
    .done    (done),
    .host_wr (host_wr),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Run stopped after %0d cycles without finishing", cycle_cnt);
      $display("TEST FAIL");
      $finish;
    end
  end

  always @(posedge clk) begin
    if (done === 1'b1)
      done_cnt <= done_cnt + 1;
  end

  ////////////////////
  // Stimulus helpers

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ TAPS) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic rand_coef(output coef_t c);
    logic [31:0] r;
    take_bits(DATA_W, r);
    if (r >= Q)
      r = r - Q;
    c = coef_t'(r);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic check_value(input string name, input logic [31:0] got_v,
                             input logic [31:0] exp_v);
    if (got_v !== exp_v) begin
      $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got_v, exp_v);
      err_count++;
    end
  endtask

  ////////////////////
  // Reference DFT

  task automatic init_powers();
    int omega;
    omega = 1;
    // 7 has order 2048, so its 128th power has order 16
    repeat (128) omega = (omega * 7) % Q;
    omega_pow[0] = 1;
    for (int i = 1; i < N_COEF; i++) begin
      omega_pow[i] = (omega_pow[i-1] * omega) % Q;
    end
  endtask

  function automatic int bitrev(int k);
    return {k[0], k[1], k[2], k[3]};
  endfunction

  task automatic build_expected();
    longint acc;
    for (int k = 0; k < N_COEF; k++) begin
      acc = 0;
      for (int n = 0; n < N_COEF; n++) begin
        acc = (acc + longint'(vec[n]) * omega_pow[(n * k) % N_COEF]) % Q;
      end
      expect_mem[bitrev(k)] = coef_t'(acc);
    end
  endtask

  ////////////////////
  // Host port and transform

  task automatic load_vector();
    for (int a = 0; a < N_COEF; a++) begin
      host_wr.en   = 1'b1;
      host_wr.addr = caddr_t'(a);
      host_wr.data = vec[a];
      next_cycle();
    end
    host_wr.en = 1'b0;
  endtask

  task automatic read_and_compare(input bit transformed);
    for (int a = 0; a < N_COEF; a++) begin
      rd_en   = 1'b1;
      rd_addr = caddr_t'(a);
      next_cycle();
      got[a] = rd_data;
    end
    rd_en = 1'b0;
    for (int a = 0; a < N_COEF; a++) begin
      check_value($sformatf("rd_data[%0d]", a), got[a],
                  transformed ? expect_mem[a] : vec[a]);
    end
  endtask

  task automatic run_transform(input bit noise, input bit restart);
    int          cycles;
    logic [31:0] r;
    coef_t       c;
    start = 1'b1;
    next_cycle();
    start  = 1'b0;
    cycles = 0;
    while (done !== 1'b1 && cycles <= NTT_CYCLES + 4) begin
      check_value("busy", busy, 1);
      if (noise) begin
        take_bits(1 + ADDR_W, r);
        host_wr.en   = r[0];
        host_wr.addr = caddr_t'(r[ADDR_W:1]);
        rand_coef(c);
        host_wr.data = c;
      end
      start = restart && (cycles == 5);
      next_cycle();
      cycles++;
    end
    host_wr.en = 1'b0;
    start      = 1'b0;
    if (done !== 1'b1) begin
      $display("done did not arrive within %0d cycles of start", cycles);
      err_count++;
    end else begin
      check_value("done cycle", cycles, NTT_CYCLES);
      check_value("busy", busy, 0);
    end
  endtask

  task automatic begin_test();
    test_err_start = err_count;
  endtask

  task automatic end_test(input string name);
    test_count++;
    if (err_count == test_err_start) begin
      $display("test %0d %s: ok", test_count, name);
    end else begin
      fail_count++;
      $display("test %0d %s: %0d errors", test_count, name, err_count - test_err_start);
    end
  endtask

  task automatic transform_test(input string name, input bit reload, input bit noise,
                                input bit restart);
    begin_test();
    if (reload)
      load_vector();
    build_expected();
    done_mark = done_cnt;
    run_transform(noise, restart);
    // Room for a second done if the late start had been taken
    if (restart)
      repeat (NTT_CYCLES + 4) next_cycle();
    read_and_compare(1'b1);
    if (done_cnt - done_mark != 1) begin
      $display("expected one done pulse per start, saw %0d", done_cnt - done_mark);
      err_count++;
    end
    end_test(name);
  endtask

  task automatic fill_random();
    for (int a = 0; a < N_COEF; a++) begin
      rand_coef(vec[a]);
    end
  endtask

  ////////////////////
  // Test sequence

  initial begin
    rst     = 1'b1;
    start   = 1'b0;
    host_wr = '0;
    rd_en   = 1'b0;
    rd_addr = '0;
    lfsr    = SEED;
    init_powers();
    repeat (5) @(posedge clk);
    #2 rst = 1'b0;

    begin_test();
    repeat (10) begin
      check_value("busy", busy, 0);
      check_value("done", done, 0);
      next_cycle();
    end
    end_test("idle after reset");

    begin_test();
    fill_random();
    load_vector();
    read_and_compare(1'b0);
    end_test("host write and readback");

    transform_test("start and done timing", 1'b0, 1'b0, 1'b0);

    for (int i = 0; i < 8; i++) begin
      fill_random();
      transform_test($sformatf("random vector %0d", i), 1'b1, 1'b0, 1'b0);
    end

    for (int a = 0; a < N_COEF; a++) begin
      vec[a] = '0;
    end
    transform_test("all zero vector", 1'b1, 1'b0, 1'b0);
    vec[0] = coef_t'(1);
    transform_test("impulse at address 0", 1'b1, 1'b0, 1'b0);

    fill_random();
    transform_test("host writes while busy", 1'b1, 1'b1, 1'b0);
    fill_random();
    transform_test("start while busy", 1'b1, 1'b0, 1'b1);

    if (i_dut.i_chk.fail_cnt != 0) begin
      $display("bound checker saw %0d assertion failures", i_dut.i_chk.fail_cnt);
      err_count += i_dut.i_chk.fail_cnt;
    end

    $display("tests %0d, failed %0d, errors %0d", test_count, fail_count, err_count);
    if (err_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* list.f */
logic/ntt_pkg.sv
logic/ntt_ctrl.sv
logic/bank_map.sv
logic/coeff_banks.sv
logic/twiddle_rom.sv
logic/mod_butterfly.sv
logic/bf_array.sv
logic/ntt_top.sv
tests/ntt_chk.sv
tests/ntt_tb.sv

/* Bender.yml */
package:
  name: ntt

sources:
  - logic/ntt_pkg.sv
  - logic/ntt_ctrl.sv
  - logic/bank_map.sv
  - logic/coeff_banks.sv
  - logic/twiddle_rom.sv
  - logic/mod_butterfly.sv
  - logic/bf_array.sv
  - logic/ntt_top.sv
  - target: test
    files:
      - tests/ntt_chk.sv
      - tests/ntt_tb.sv
